// File: source/sniff_pkg.sv
/*
 * Shared types and constants for the CCI-P protocol checker.
 * Every checker and the reporter import this package.
 */
package sniff_pkg;

   // Channel 0 read request types, others illegal
   typedef enum logic [3:0] {
      RDLINE_I = 4'h0,
      RDLINE_S = 4'h1
   } c0_req_t;

   // Channel 1 write and fence types, others illegal
   typedef enum logic [3:0] {
      WRLINE_I = 4'h0,
      WRLINE_M = 4'h1,
      WRFENCE  = 4'h4
   } c1_req_t;

   // Lines per request, 3 lines is never legal
   typedef enum logic [1:0] {
      LEN_1 = 2'd0,
      LEN_2 = 2'd1,
      LEN_3 = 2'd2,
      LEN_4 = 2'd3
   } cl_len_t;

   localparam int VC_W         = 2;
   localparam int ADDR_LOW_W   = 2;
   localparam int MMIO_TID_W   = 4;
   localparam int MMIO_SLOTS   = 16;
   localparam int MMIO_TIMEOUT = 64;
   localparam int MMIO_TIMER_W = 7;

   // Error codes, lower value wins arbitration
   typedef enum logic [4:0] {
      NO_ERROR,
      C0_INVALID_REQTYPE,
      C0_3CL_REQUEST,
      C0_ADDRALIGN_2,
      C0_ADDRALIGN_4,
      C1_INVALID_REQTYPE,
      C1_3CL_REQUEST,
      C1_ADDRALIGN_2,
      C1_ADDRALIGN_4,
      C1_SOP_NOT_SET,
      C1_SOP_SET_MCL,
      C1_UNEXP_VCSEL,
      C1_UNEXP_REQTYPE,
      C1_UNEXP_ADDR,
      C1_WRFENCE_IN_MCL,
      MMIO_RDRSP_TIMEOUT,
      MMIO_RDRSP_UNSOLICITED
   } sniff_code_t;

   // Report stream
   localparam int REPORT_CREDITS    = 4;
   localparam int REPORT_FIFO_DEPTH = 4;
   localparam int DROP_W            = 8;
   localparam int REPORT_CREDIT_W   = $clog2(REPORT_CREDITS + 1);
   localparam int REPORT_PTR_W      = $clog2(REPORT_FIFO_DEPTH);
   localparam int REPORT_CNT_W      = $clog2(REPORT_FIFO_DEPTH + 1);

endpackage

// File: source/req_capture.sv
/*
 * Input stage of the checker. Samples every watched request and MMIO
 * signal once so all checkers work on the same aligned cycle.
 */
`timescale 1ns/1ns

module req_capture
   import sniff_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  c0_valid,
   input  c0_req_t               c0_req_type,
   input  cl_len_t               c0_cl_len,
   input  logic [ADDR_LOW_W-1:0] c0_addr_low,
   input  logic                  c1_valid,
   input  c1_req_t               c1_req_type,
   input  cl_len_t               c1_cl_len,
   input  logic                  c1_sop,
   input  logic [VC_W-1:0]       c1_vc_sel,
   input  logic [ADDR_LOW_W-1:0] c1_addr_low,
   input  logic                  mmio_req_valid,
   input  logic [MMIO_TID_W-1:0] mmio_req_tid,
   input  logic                  mmio_rsp_valid,
   input  logic [MMIO_TID_W-1:0] mmio_rsp_tid,
   output logic                  r_c0_valid,
   output c0_req_t               r_c0_req_type,
   output cl_len_t               r_c0_cl_len,
   output logic [ADDR_LOW_W-1:0] r_c0_addr_low,
   output logic                  r_c1_valid,
   output c1_req_t               r_c1_req_type,
   output cl_len_t               r_c1_cl_len,
   output logic                  r_c1_sop,
   output logic [VC_W-1:0]       r_c1_vc_sel,
   output logic [ADDR_LOW_W-1:0] r_c1_addr_low,
   output logic                  r_mmio_req_valid,
   output logic [MMIO_TID_W-1:0] r_mmio_req_tid,
   output logic                  r_mmio_rsp_valid,
   output logic [MMIO_TID_W-1:0] r_mmio_rsp_tid
);

   // Valid strobes
   always_ff @(posedge clk) begin
      if (rst) begin
         r_c0_valid       <= 1'b0;
         r_c1_valid       <= 1'b0;
         r_mmio_req_valid <= 1'b0;
         r_mmio_rsp_valid <= 1'b0;
      end else begin
         r_c0_valid       <= c0_valid;
         r_c1_valid       <= c1_valid;
         r_mmio_req_valid <= mmio_req_valid;
         r_mmio_rsp_valid <= mmio_rsp_valid;
      end
   end

   // Header fields, only meaningful with their valid
   always_ff @(posedge clk) begin
      r_c0_req_type  <= c0_req_type;
      r_c0_cl_len    <= c0_cl_len;
      r_c0_addr_low  <= c0_addr_low;
      r_c1_req_type  <= c1_req_type;
      r_c1_cl_len    <= c1_cl_len;
      r_c1_sop       <= c1_sop;
      r_c1_vc_sel    <= c1_vc_sel;
      r_c1_addr_low  <= c1_addr_low;
      r_mmio_req_tid <= mmio_req_tid;
      r_mmio_rsp_tid <= mmio_rsp_tid;
   end

   // Sampled type must be known whenever the request was valid
   a_c0_type_known: assert property (@(posedge clk) disable iff (rst)
      c0_valid |=> !$isunknown(r_c0_req_type));
   a_c1_type_known: assert property (@(posedge clk) disable iff (rst)
      c1_valid |=> !$isunknown(r_c1_req_type));

endmodule

// File: source/rd_req_checker.sv
/*
 * Channel 0 read request rules. Flags an illegal type, a 3-line
 * request and misaligned multi-line reads, one code per request.
 */
`timescale 1ns/1ns

module rd_req_checker
   import sniff_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  r_c0_valid,
   input  c0_req_t               r_c0_req_type,
   input  cl_len_t               r_c0_cl_len,
   input  logic [ADDR_LOW_W-1:0] r_c0_addr_low,
   output sniff_code_t           rd_code
);

   sniff_code_t code_next;
   logic        type_ok;

   assign type_ok = r_c0_req_type inside {RDLINE_I, RDLINE_S};

   // Priority chain, lowest code first
   always_comb begin
      code_next = NO_ERROR;
      if (r_c0_valid) begin
         if (!type_ok)
            code_next = C0_INVALID_REQTYPE;
         else if (r_c0_cl_len == LEN_3)
            code_next = C0_3CL_REQUEST;
         // 2-line needs even line address
         else if (r_c0_cl_len == LEN_2 && r_c0_addr_low[0])
            code_next = C0_ADDRALIGN_2;
         // 4-line needs both low bits clear
         else if (r_c0_cl_len == LEN_4 && r_c0_addr_low != '0)
            code_next = C0_ADDRALIGN_4;
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         rd_code <= NO_ERROR;
      else
         rd_code <= code_next;
   end

endmodule

// File: source/wr_mcl_checker.sv
/*
 * Channel 1 multi-line write sequence checker. Tracks the beat of the
 * current burst and checks each beat against the SOP beat.
 */
`timescale 1ns/1ns

module wr_mcl_checker
   import sniff_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  r_c1_valid,
   input  c1_req_t               r_c1_req_type,
   input  cl_len_t               r_c1_cl_len,
   input  logic                  r_c1_sop,
   input  logic [VC_W-1:0]       r_c1_vc_sel,
   input  logic [ADDR_LOW_W-1:0] r_c1_addr_low,
   output sniff_code_t           wr_code
);

   // Encoding doubles as the beat index within the burst
   typedef enum logic [1:0] {
      expect_first  = 2'd0,
      expect_second = 2'd1,
      expect_third  = 2'd2,
      expect_fourth = 2'd3
   } state_t;

   state_t                state;
   state_t                state_next;
   sniff_code_t           code_next;
   c1_req_t               base_type;
   cl_len_t               base_len;
   logic [VC_W-1:0]       base_vc;
   logic [ADDR_LOW_W-1:0] base_addr;
   logic [ADDR_LOW_W-1:0] beat_idx;
   logic                  is_write;
   logic                  is_fence;
   logic                  last_beat;

   assign is_write  = r_c1_valid && (r_c1_req_type inside {WRLINE_I, WRLINE_M});
   assign is_fence  = r_c1_valid && (r_c1_req_type == WRFENCE);
   assign beat_idx  = ADDR_LOW_W'(state);
   // 2-line burst ends after the second beat
   assign last_beat = (state == expect_fourth) ||
                      (state == expect_second && base_len == LEN_2);

   always_comb begin
      code_next  = NO_ERROR;
      state_next = state;
      if (r_c1_valid && !is_write && !is_fence) begin
         code_next = C1_INVALID_REQTYPE;
      end else if (state == expect_first) begin
         // Fence is legal here and needs no checks
         if (is_write) begin
            if (r_c1_cl_len == LEN_3)
               code_next = C1_3CL_REQUEST;
            else if (r_c1_cl_len == LEN_2 && r_c1_addr_low[0])
               code_next = C1_ADDRALIGN_2;
            else if (r_c1_cl_len == LEN_4 && r_c1_addr_low != '0)
               code_next = C1_ADDRALIGN_4;
            else if (!r_c1_sop)
               code_next = C1_SOP_NOT_SET;
            if (r_c1_sop && (r_c1_cl_len inside {LEN_2, LEN_4}))
               state_next = expect_second;
         end
      end else if (is_fence) begin
         // Fence mid burst keeps the burst open
         code_next = C1_WRFENCE_IN_MCL;
      end else if (is_write) begin
         if (r_c1_sop)
            code_next = C1_SOP_SET_MCL;
         else if (r_c1_vc_sel != base_vc)
            code_next = C1_UNEXP_VCSEL;
         else if (r_c1_req_type != base_type)
            code_next = C1_UNEXP_REQTYPE;
         else if (r_c1_addr_low != base_addr + beat_idx)
            code_next = C1_UNEXP_ADDR;
         state_next = last_beat ? expect_first : state_t'(state + 2'd1);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= expect_first;
         wr_code <= NO_ERROR;
      end else begin
         state   <= state_next;
         wr_code <= code_next;
      end
   end

   // Burst reference taken from the SOP beat
   always_ff @(posedge clk) begin
      if (state == expect_first && is_write && r_c1_sop) begin
         base_type <= r_c1_req_type;
         base_len  <= r_c1_cl_len;
         base_vc   <= r_c1_vc_sel;
         base_addr <= r_c1_addr_low;
      end
   end

   // Third and fourth beats only exist inside a 4-line burst
   a_late_beat_len4: assert property (@(posedge clk) disable iff (rst)
      (state inside {expect_third, expect_fourth}) |-> base_len == LEN_4);

endmodule

// File: source/mmio_rsp_tracker.sv
/*
 * Outstanding MMIO read tracker, one slot per transaction ID.
 * Flags responses with no open request and requests left open too long.
 */
`timescale 1ns/1ns

module mmio_rsp_tracker
   import sniff_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  r_mmio_req_valid,
   input  logic [MMIO_TID_W-1:0] r_mmio_req_tid,
   input  logic                  r_mmio_rsp_valid,
   input  logic [MMIO_TID_W-1:0] r_mmio_rsp_tid,
   output sniff_code_t           mmio_code
);

   logic [MMIO_SLOTS-1:0]   active;
   logic [MMIO_SLOTS-1:0]   reported;
   logic [MMIO_SLOTS-1:0]   timeout_hit;
   logic [MMIO_TIMER_W-1:0] timer [MMIO_SLOTS];
   logic                    unsolicited;
   sniff_code_t             code_next;

   assign unsolicited = r_mmio_rsp_valid && !active[r_mmio_rsp_tid];

   // Timer at limit and not yet flagged
   always_comb begin
      for (int i = 0; i < MMIO_SLOTS; i++) begin
         timeout_hit[i] = active[i] && !reported[i] &&
                          (timer[i] == MMIO_TIMER_W'(MMIO_TIMEOUT));
      end
   end

   always_comb begin
      code_next = NO_ERROR;
      if (timeout_hit != '0)
         code_next = MMIO_RDRSP_TIMEOUT;
      else if (unsolicited)
         code_next = MMIO_RDRSP_UNSOLICITED;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active    <= '0;
         reported  <= '0;
         mmio_code <= NO_ERROR;
         for (int i = 0; i < MMIO_SLOTS; i++)
            timer[i] <= '0;
      end else begin
         mmio_code <= code_next;
         for (int i = 0; i < MMIO_SLOTS; i++) begin
            // New request reopens the slot even if still active
            if (r_mmio_req_valid && r_mmio_req_tid == MMIO_TID_W'(i)) begin
               active[i]   <= 1'b1;
               reported[i] <= 1'b0;
               timer[i]    <= '0;
            end else if (r_mmio_rsp_valid && r_mmio_rsp_tid == MMIO_TID_W'(i)) begin
               active[i] <= 1'b0;
            end else if (active[i]) begin
               // Counter parks at the limit
               if (timer[i] != MMIO_TIMER_W'(MMIO_TIMEOUT))
                  timer[i] <= timer[i] + 1'b1;
               if (timeout_hit[i])
                  reported[i] <= 1'b1;
            end
         end
      end
   end

endmodule

// File: source/error_reporter.sv
/*
 * Output stage. Arbitrates the checker codes, queues the winner and
 * sends queued codes out under credit-based flow control.
 */
`timescale 1ns/1ns

module error_reporter
   import sniff_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  sniff_code_t       rd_code,
   input  sniff_code_t       wr_code,
   input  sniff_code_t       mmio_code,
   input  logic              credit_return,
   output logic              report_valid,
   output sniff_code_t       report_code,
   output logic [DROP_W-1:0] drop_count
);

   sniff_code_t                fifo_mem [REPORT_FIFO_DEPTH];
   logic [REPORT_PTR_W-1:0]    wr_ptr;
   logic [REPORT_PTR_W-1:0]    rd_ptr;
   logic [REPORT_CNT_W-1:0]    fifo_cnt;
   logic [REPORT_CREDIT_W-1:0] credits;
   sniff_code_t                win_code;
   logic [1:0]                 n_codes;
   logic [1:0]                 drop_inc;
   logic                       push;
   logic                       pop;
   logic [DROP_W:0]            drop_sum;

   // Lowest nonzero code wins
   always_comb begin
      win_code = mmio_code;
      if (wr_code != NO_ERROR && (win_code == NO_ERROR || wr_code < win_code))
         win_code = wr_code;
      if (rd_code != NO_ERROR && (win_code == NO_ERROR || rd_code < win_code))
         win_code = rd_code;
      n_codes = 2'(rd_code != NO_ERROR) + 2'(wr_code != NO_ERROR) +
                2'(mmio_code != NO_ERROR);
   end

   // Send side, one code per credit
   assign pop          = (credits != '0) && (fifo_cnt != '0);
   assign report_valid = pop;
   assign report_code  = fifo_mem[rd_ptr];

   // A full queue still accepts when a code leaves the same cycle
   assign push = (win_code != NO_ERROR) &&
                 ((fifo_cnt != REPORT_CNT_W'(REPORT_FIFO_DEPTH)) || pop);

   // Losers plus a winner that found no room
   assign drop_inc = (n_codes == 2'd0) ? 2'd0 :
                     (n_codes - 2'd1) + 2'((win_code != NO_ERROR) && !push);
   assign drop_sum = {1'b0, drop_count} + (DROP_W + 1)'(drop_inc);

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_cnt   <= '0;
         credits    <= REPORT_CREDIT_W'(REPORT_CREDITS);
         drop_count <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         fifo_cnt <= fifo_cnt + REPORT_CNT_W'(push) - REPORT_CNT_W'(pop);
         credits  <= credits - REPORT_CREDIT_W'(pop) + REPORT_CREDIT_W'(credit_return);
         // Saturate
         drop_count <= drop_sum[DROP_W] ? '1 : drop_sum[DROP_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         fifo_mem[wr_ptr] <= win_code;
   end

   // Receiver side must keep the credit loop balanced
   a_credits_bounded: assert property (@(posedge clk) disable iff (rst)
      credits <= REPORT_CREDIT_W'(REPORT_CREDITS));
   a_no_extra_return: assert property (@(posedge clk) disable iff (rst)
      credit_return |-> credits != REPORT_CREDIT_W'(REPORT_CREDITS));

endmodule

// File: source/ccip_sniffer.sv
/*
 * Top level of the CCI-P protocol checker. Input stage feeds the read,
 * write and MMIO checkers, whose codes go to the credited reporter.
 */
`timescale 1ns/1ns

module ccip_sniffer
   import sniff_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  c0_valid,
   input  c0_req_t               c0_req_type,
   input  cl_len_t               c0_cl_len,
   input  logic [ADDR_LOW_W-1:0] c0_addr_low,
   input  logic                  c1_valid,
   input  c1_req_t               c1_req_type,
   input  cl_len_t               c1_cl_len,
   input  logic                  c1_sop,
   input  logic [VC_W-1:0]       c1_vc_sel,
   input  logic [ADDR_LOW_W-1:0] c1_addr_low,
   input  logic                  mmio_req_valid,
   input  logic [MMIO_TID_W-1:0] mmio_req_tid,
   input  logic                  mmio_rsp_valid,
   input  logic [MMIO_TID_W-1:0] mmio_rsp_tid,
   input  logic                  credit_return,
   output logic                  report_valid,
   output sniff_code_t           report_code,
   output logic [DROP_W-1:0]     drop_count
);

   // Sampled inputs
   logic                  r_c0_valid;
   c0_req_t               r_c0_req_type;
   cl_len_t               r_c0_cl_len;
   logic [ADDR_LOW_W-1:0] r_c0_addr_low;
   logic                  r_c1_valid;
   c1_req_t               r_c1_req_type;
   cl_len_t               r_c1_cl_len;
   logic                  r_c1_sop;
   logic [VC_W-1:0]       r_c1_vc_sel;
   logic [ADDR_LOW_W-1:0] r_c1_addr_low;
   logic                  r_mmio_req_valid;
   logic [MMIO_TID_W-1:0] r_mmio_req_tid;
   logic                  r_mmio_rsp_valid;
   logic [MMIO_TID_W-1:0] r_mmio_rsp_tid;

   // Checker codes
   sniff_code_t rd_code;
   sniff_code_t wr_code;
   sniff_code_t mmio_code;

   req_capture req_capture_i (.*);

   rd_req_checker rd_req_checker_i (.*);

   wr_mcl_checker wr_mcl_checker_i (.*);

   mmio_rsp_tracker mmio_rsp_tracker_i (.*);

   error_reporter error_reporter_i (.*);

endmodule

// File: dv/sniff_scoreboard.sv
/*
 * Testbench checker for the protocol checker's report stream.
 * Queues expected codes from the stimulus loop and compares every report.
 */
`timescale 1ns/1ns

module sniff_scoreboard
   import sniff_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              report_valid,
   input  sniff_code_t       report_code,
   input  logic [DROP_W-1:0] drop_count,
   input  logic              exp_valid,
   input  sniff_code_t       exp_code,
   input  logic              test_end,
   input  int                exp_drops,
   input  logic [159:0]      test_name,
   input  logic              done,
   output int                error_count,
   output int                test_count
);

   sniff_code_t pending [$];
   sniff_code_t want;
   int          test_errors;
   int          test_fails;
   logic        summary_done;

   always @(posedge clk) begin
      if (rst) begin
         pending.delete();
         test_errors  = 0;
         test_fails   = 0;
         error_count  = 0;
         test_count   = 0;
         summary_done = 1'b0;
      end else begin
         if (exp_valid)
            pending.push_back(exp_code);
         if (report_valid) begin
            if (pending.size() == 0) begin
               $display("test %0s: unexpected report with code %s", test_name,
                        report_code.name());
               test_errors++;
            end else begin
               want = pending.pop_front();
               if (report_code != want) begin
                  $display("error test %0s: expected %s, actual %s", test_name,
                           want.name(), report_code.name());
                  test_errors++;
               end
            end
         end
         // Test boundary, leftovers mean lost reports
         if (test_end) begin
            if (pending.size() != 0) begin
               $display("test %0s: %0d expected reports never arrived", test_name,
                        pending.size());
               test_errors++;
               pending.delete();
            end
            if (int'(drop_count) != exp_drops) begin
               $display("error test %0s: drop_count expected %0d, actual %0d",
                        test_name, exp_drops, int'(drop_count));
               test_errors++;
            end
            if (test_errors == 0) begin
               $display("test %0s: passed", test_name);
            end else begin
               $display("test %0s: failed with %0d errors", test_name, test_errors);
               test_fails++;
            end
            error_count += test_errors;
            test_errors = 0;
            test_count++;
         end
         if (done && !summary_done) begin
            $display("tests run %0d, passed %0d, failed %0d, errors %0d", test_count,
                     test_count - test_fails, test_fails, error_count);
            summary_done = 1'b1;
         end
      end
   end

endmodule

// File: dv/ccip_sniffer_tb.sv
/*
 * Top testbench for the protocol checker. Builds a step table, drives it
 * into the DUT, returns credits after random delays and limits run time.
 */
`timescale 1ns/1ns

module ccip_sniffer_tb;
   import sniff_pkg::*;

   // One table step is a single input cycle plus idle cycles
   typedef struct packed {
      logic [159:0] name;
      logic         c0_v;
      logic [3:0]   c0_type;
      logic [1:0]   c0_len;
      logic [1:0]   c0_addr;
      logic         c1_v;
      logic [3:0]   c1_type;
      logic [1:0]   c1_len;
      logic         c1_sop;
      logic [1:0]   c1_vc;
      logic [1:0]   c1_addr;
      logic         mreq_v;
      logic [3:0]   mreq_tid;
      logic         mrsp_v;
      logic [3:0]   mrsp_tid;
      int           idle;
      sniff_code_t  exp;
      int           exp_drops;
      logic         hold;
      logic         last;
   } step_t;

   logic clk;
   logic rst;
   logic c0_valid;
   c0_req_t c0_req_type;
   cl_len_t c0_cl_len;
   logic [ADDR_LOW_W-1:0] c0_addr_low;
   logic c1_valid;
   c1_req_t c1_req_type;
   cl_len_t c1_cl_len;
   logic c1_sop;
   logic [VC_W-1:0] c1_vc_sel;
   logic [ADDR_LOW_W-1:0] c1_addr_low;
   logic mmio_req_valid;
   logic [MMIO_TID_W-1:0] mmio_req_tid;
   logic mmio_rsp_valid;
   logic [MMIO_TID_W-1:0] mmio_rsp_tid;
   logic credit_return = 1'b0;
   logic report_valid;
   sniff_code_t report_code;
   logic [DROP_W-1:0] drop_count;

   // Scoreboard side
   logic exp_valid;
   sniff_code_t exp_code;
   logic test_end;
   int exp_drops;
   logic [159:0] test_name;
   logic done;
   int error_count;
   int test_count;

   step_t steps [$];
   logic hold_credits;
   logic [7:0] lfsr;
   int owed;
   int delay_cnt;
   int timeout_cycles;

   ccip_sniffer ccip_sniffer_i (.*);

   sniff_scoreboard sniff_scoreboard_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic step_t blank(logic [159:0] name);
      step_t s;
      s = '0;
      s.name = name;
      s.exp = NO_ERROR;
      return s;
   endfunction

   // Read with one rule broken as picked by the index
   function automatic step_t bad_read(logic [159:0] name, int idx);
      step_t s;
      s = blank(name);
      s.c0_v = 1'b1;
      case (idx % 4)
         0: begin
            s.c0_type = 4'h7;
            s.exp = C0_INVALID_REQTYPE;
         end
         1: begin
            s.c0_len = 2'd2;
            s.exp = C0_3CL_REQUEST;
         end
         2: begin
            s.c0_len = 2'd1;
            s.c0_addr = 2'd1;
            s.exp = C0_ADDRALIGN_2;
         end
         default: begin
            s.c0_len = 2'd3;
            s.c0_addr = 2'd2;
            s.exp = C0_ADDRALIGN_4;
         end
      endcase
      return s;
   endfunction

   function automatic step_t rd(logic [159:0] name, logic [3:0] t, logic [1:0] len,
                                logic [1:0] addr);
      step_t s;
      s = blank(name);
      s.c0_v = 1'b1;
      s.c0_type = t;
      s.c0_len = len;
      s.c0_addr = addr;
      return s;
   endfunction

   function automatic step_t wr(logic [159:0] name, logic [3:0] t, logic [1:0] len,
                                logic sop, logic [1:0] vc, logic [1:0] addr,
                                sniff_code_t exp);
      step_t s;
      s = blank(name);
      s.c1_v = 1'b1;
      s.c1_type = t;
      s.c1_len = len;
      s.c1_sop = sop;
      s.c1_vc = vc;
      s.c1_addr = addr;
      s.exp = exp;
      return s;
   endfunction

   function automatic step_t mmio(logic [159:0] name, logic req, logic rsp,
                                  logic [3:0] tid, sniff_code_t exp);
      step_t s;
      s = blank(name);
      s.mreq_v = req;
      s.mreq_tid = tid;
      s.mrsp_v = rsp;
      s.mrsp_tid = tid;
      s.exp = exp;
      return s;
   endfunction

   task automatic add(step_t s, int idle);
      s.idle = idle;
      steps.push_back(s);
   endtask

   // Closing step carries the cumulative drop count
   task automatic end_test(logic [159:0] name, int idle, int drops);
      step_t s;
      s = blank(name);
      s.last = 1'b1;
      s.exp_drops = drops;
      add(s, idle);
   endtask

   task automatic build_table();
      step_t s;
      add(rd("legal_traffic", 4'h1, 2'd3, 2'd0), 2);
      add(rd("legal_traffic", 4'h0, 2'd1, 2'd2), 2);
      add(wr("legal_traffic", 4'h1, 2'd3, 1'b1, 2'd1, 2'd0, NO_ERROR), 0);
      for (int b = 1; b < 4; b++)
         add(wr("legal_traffic", 4'h1, 2'd3, 1'b0, 2'd1, 2'(b), NO_ERROR), 0);
      add(wr("legal_traffic", 4'h4, 2'd0, 1'b0, 2'd0, 2'd0, NO_ERROR), 2);
      add(mmio("legal_traffic", 1'b1, 1'b0, 4'd1, NO_ERROR), 5);
      add(mmio("legal_traffic", 1'b0, 1'b1, 4'd1, NO_ERROR), 2);
      end_test("legal_traffic", 20, 0);
      for (int i = 0; i < 4; i++)
         add(bad_read("read_rules", i), 3);
      end_test("read_rules", 20, 0);
      add(wr("write_rules", 4'h0, 2'd0, 1'b0, 2'd0, 2'd0, C1_SOP_NOT_SET), 3);
      add(wr("write_rules", 4'h0, 2'd1, 1'b1, 2'd0, 2'd0, NO_ERROR), 0);
      add(wr("write_rules", 4'h0, 2'd1, 1'b1, 2'd0, 2'd1, C1_SOP_SET_MCL), 3);
      add(wr("write_rules", 4'h0, 2'd1, 1'b1, 2'd0, 2'd0, NO_ERROR), 0);
      add(wr("write_rules", 4'h0, 2'd1, 1'b0, 2'd1, 2'd1, C1_UNEXP_VCSEL), 3);
      add(wr("write_rules", 4'h0, 2'd1, 1'b1, 2'd0, 2'd0, NO_ERROR), 0);
      add(wr("write_rules", 4'h1, 2'd1, 1'b0, 2'd0, 2'd1, C1_UNEXP_REQTYPE), 3);
      add(wr("write_rules", 4'h0, 2'd1, 1'b1, 2'd0, 2'd2, NO_ERROR), 0);
      add(wr("write_rules", 4'h0, 2'd1, 1'b0, 2'd0, 2'd2, C1_UNEXP_ADDR), 3);
      // Fence leaves the burst open and the second beat still closes it
      add(wr("write_rules", 4'h0, 2'd1, 1'b1, 2'd0, 2'd0, NO_ERROR), 0);
      add(wr("write_rules", 4'h4, 2'd0, 1'b0, 2'd0, 2'd0, C1_WRFENCE_IN_MCL), 0);
      add(wr("write_rules", 4'h0, 2'd1, 1'b0, 2'd0, 2'd1, NO_ERROR), 3);
      add(wr("write_rules", 4'h0, 2'd2, 1'b1, 2'd0, 2'd0, C1_3CL_REQUEST), 3);
      end_test("write_rules", 20, 0);
      add(mmio("mmio_rules", 1'b0, 1'b1, 4'd5, MMIO_RDRSP_UNSOLICITED), 5);
      add(mmio("mmio_rules", 1'b1, 1'b0, 4'd3, MMIO_RDRSP_TIMEOUT), MMIO_TIMEOUT + 30);
      end_test("mmio_rules", 20, 0);
      // Four sent, four queued and two dropped
      for (int i = 0; i < 10; i++) begin
         s = bad_read("credit_backpressure", i);
         s.hold = 1'b1;
         if (i >= 8)
            s.exp = NO_ERROR;
         add(s, 3);
      end
      end_test("credit_backpressure", 60, 2);
      // Read type error beats the write 3-line error
      s = bad_read("same_cycle", 0);
      s.c1_v = 1'b1;
      s.c1_len = 2'd2;
      s.c1_sop = 1'b1;
      add(s, 30);
      end_test("same_cycle", 20, 3);
   endtask

   // Galois LFSR stepped once per bit taken
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
         lfsr = lfsr ^ 8'hB8;
      return b;
   endfunction

   // Credits go back only for reports already seen
   always @(posedge clk) begin
      if (rst) begin
         credit_return <= 1'b0;
         owed = 0;
         delay_cnt = 0;
      end else begin
         credit_return <= 1'b0;
         if (report_valid)
            owed++;
         if (delay_cnt != 0) begin
            delay_cnt--;
         end else if (owed > 0 && !hold_credits) begin
            credit_return <= 1'b1;
            owed--;
            // Gap before the next return, 0 to 7 cycles
            for (int k = 0; k < 3; k++)
               delay_cnt = (delay_cnt << 1) | int'(lfsr_bit());
         end
      end
   end

   task automatic apply(step_t s);
      c0_valid <= s.c0_v;
      c0_req_type <= c0_req_t'(s.c0_type);
      c0_cl_len <= cl_len_t'(s.c0_len);
      c0_addr_low <= s.c0_addr;
      c1_valid <= s.c1_v;
      c1_req_type <= c1_req_t'(s.c1_type);
      c1_cl_len <= cl_len_t'(s.c1_len);
      c1_sop <= s.c1_sop;
      c1_vc_sel <= s.c1_vc;
      c1_addr_low <= s.c1_addr;
      mmio_req_valid <= s.mreq_v;
      mmio_req_tid <= s.mreq_tid;
      mmio_rsp_valid <= s.mrsp_v;
      mmio_rsp_tid <= s.mrsp_tid;
   endtask

   initial begin
      int n_tests;
      int total;
      n_tests = 0;
      total = 0;
      lfsr = 8'd62;
      timeout_cycles = 0;
      rst = 1'b1;
      hold_credits = 1'b0;
      exp_valid = 1'b0;
      exp_code = NO_ERROR;
      test_end = 1'b0;
      exp_drops = 0;
      test_name = '0;
      done = 1'b0;
      apply(blank(""));
      build_table();
      // Each step costs its drive cycle, a blank cycle, idle and the end pulse
      foreach (steps[i]) begin
         n_tests += int'(steps[i].last);
         total += 2 + steps[i].idle + int'(steps[i].last);
      end
      timeout_cycles = total + 10 + 200;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      foreach (steps[i]) begin
         @(posedge clk);
         apply(steps[i]);
         test_name <= steps[i].name;
         hold_credits <= steps[i].hold;
         exp_valid <= (steps[i].exp != NO_ERROR);
         exp_code <= steps[i].exp;
         @(posedge clk);
         apply(blank(steps[i].name));
         exp_valid <= 1'b0;
         repeat (steps[i].idle) @(posedge clk);
         if (steps[i].last) begin
            test_end <= 1'b1;
            exp_drops <= steps[i].exp_drops;
            @(posedge clk);
            test_end <= 1'b0;
         end
      end
      @(posedge clk);
      done <= 1'b1;
      repeat (2) @(posedge clk);
      if (error_count == 0 && test_count == n_tests) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog sized from the table
   initial begin
      wait (timeout_cycles != 0);
      repeat (timeout_cycles) @(posedge clk);
      $display("watchdog expired before the table finished");
      $display("Test failed");
      $finish;
   end

endmodule

// File: files.f
source/sniff_pkg.sv
source/req_capture.sv
source/rd_req_checker.sv
source/wr_mcl_checker.sv
source/mmio_rsp_tracker.sv
source/error_reporter.sv
source/ccip_sniffer.sv
dv/sniff_scoreboard.sv
dv/ccip_sniffer_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the checker testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
   --top-module ccip_sniffer_tb -o ccip_sniffer_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/ccip_sniffer_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
   exit 0
fi
exit 1
